/* src/vpipe_pkg.sv */
// Core types for a 16-bit ISA with ALU ops only, no branches or data memory, 256-word code space
`default_nettype none

package vpipe_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes

  localparam int xlen        = 16;  // Register width
  localparam int nregs       = 8;   // r0 hardwired to zero
  localparam int pc_bits     = 8;   // Word address
  localparam int line_words  = 4;   // Instructions per cache line
  localparam int cache_lines = 8;

  // Cache address split of a pc, tag | index | offset
  localparam int off_bits = $clog2(line_words);
  localparam int idx_bits = $clog2(cache_lines);
  localparam int tag_bits = pc_bits - idx_bits - off_bits;

  typedef logic [xlen-1:0]             word_t;
  typedef logic [15:0]                 inst_t;
  typedef logic [pc_bits-1:0]          pc_t;
  typedef logic [$clog2(nregs)-1:0]    reg_idx_t;
  // Word k of a line sits in bits k*16+15 .. k*16
  typedef logic [line_words*16-1:0]    line_t;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings

  // Fields: op 15..12, rd 11..9, rs1 8..6, rs2 5..3
  // addi imm is 5..0 signed, li imm is 8..0 unsigned
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_addi = 4'd5,
    op_li   = 4'd6,   // Highest legal ALU op
    op_halt = 4'd15   // 7..14 are illegal
  } opcode_t;

  typedef enum logic [1:0] {
    st_ok      = 2'd0,
    st_halt    = 2'd1,
    st_illegal = 2'd2
  } status_t;

  ////////////////////////////////////////////////////////////////////////////
  // Packets

  typedef struct packed {
    pc_t addr;  // Always line aligned
  } mem_req_t;

  typedef struct packed {
    line_t data;
  } mem_rsp_t;

  typedef struct packed {
    pc_t   pc;
    inst_t inst;
  } fetch_pkt_t;

  typedef struct packed {
    pc_t      pc;
    opcode_t  op;
    reg_idx_t rd;
    logic     wr_en;
    word_t    a;       // rs1 value
    word_t    b;       // rs2 value or raw immediate field
    status_t  status;
  } decode_pkt_t;

  // Also the writeback bundle from commit to decode
  typedef struct packed {
    pc_t      pc;
    reg_idx_t rd;
    logic     wr_en;
    word_t    result;
    status_t  status;
  } exec_pkt_t;

  typedef struct packed {
    pc_t      pc;
    reg_idx_t rd;
    logic     wr_en;
    word_t    data;
    status_t  status;
  } commit_t;

endpackage

`default_nettype wire

/* src/fetch_cache.sv */
// Sequential fetch only; one refill outstanding, response must come back on a later cycle
`timescale 1ns/1ns
`default_nettype none

module fetch_cache (
  input  logic                   clock,
  input  logic                   reset,
  // Instruction memory
  output logic                   mem_req_valid,
  output vpipe_pkg::mem_req_t    mem_req,
  input  logic                   mem_req_ready,
  input  logic                   mem_rsp_valid,
  input  vpipe_pkg::mem_rsp_t    mem_rsp,
  // To decode
  output logic                   fetch_valid,
  output vpipe_pkg::fetch_pkt_t  fetch_pkt,
  input  logic                   fetch_ready
);

  typedef enum logic [1:0] {
    fs_idle,
    fs_request,  // Holding mem_req_valid
    fs_wait      // Waiting for the line
  } fetch_state_t;

  fetch_state_t state;

  vpipe_pkg::pc_t pc;
  logic           stopped;  // Halt or illegal already handed off

  logic [vpipe_pkg::tag_bits-1:0] pc_tag;
  logic [vpipe_pkg::idx_bits-1:0] pc_idx;
  logic [vpipe_pkg::off_bits-1:0] pc_off;

  // Direct-mapped storage
  vpipe_pkg::line_t               lines [vpipe_pkg::cache_lines];
  logic [vpipe_pkg::tag_bits-1:0] tags  [vpipe_pkg::cache_lines];
  logic [vpipe_pkg::cache_lines-1:0] line_valid;

  logic             hit;
  logic             rsp_now;
  vpipe_pkg::line_t cur_line;
  vpipe_pkg::inst_t cur_inst;
  logic             word_ok;
  logic             out_free;
  logic             take;
  logic             stop_op;

  assign {pc_tag, pc_idx, pc_off} = pc;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup

  assign hit     = line_valid[pc_idx] && (tags[pc_idx] == pc_tag);
  assign rsp_now = (state == fs_wait) && mem_rsp_valid;

  // Refill data bypasses the array in the response cycle
  assign cur_line = rsp_now ? mem_rsp.data : lines[pc_idx];
  assign cur_inst = cur_line[pc_off*16 +: 16];

  assign word_ok  = ((state == fs_idle) && hit) || rsp_now;
  assign out_free = !fetch_valid || fetch_ready;  // Output empty or draining
  assign take     = word_ok && !stopped && out_free;

  // Anything above li is halt or illegal
  assign stop_op = vpipe_pkg::opcode_t'(cur_inst[15:12]) > vpipe_pkg::op_li;

  // Line-aligned address straight from pc, which holds during a refill
  assign mem_req_valid = (state == fs_request);
  assign mem_req.addr  = {pc_tag, pc_idx, {vpipe_pkg::off_bits{1'b0}}};

  ////////////////////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= fs_idle;
      pc          <= '0;
      stopped     <= 1'b0;
      fetch_valid <= 1'b0;
      line_valid  <= '0;  // Cold cache
    end else begin
      case (state)
        fs_idle: begin
          if (!hit && !stopped) state <= fs_request;  // Miss seen
        end
        fs_request: begin
          if (mem_req_ready) state <= fs_wait;
        end
        fs_wait: begin
          if (mem_rsp_valid) begin
            state              <= fs_idle;
            line_valid[pc_idx] <= 1'b1;
          end
        end
        default: state <= fs_idle;
      endcase

      if (take) begin
        pc          <= pc + 1'b1;
        fetch_valid <= 1'b1;
        if (stop_op) stopped <= 1'b1;  // Last fetch of the program
      end else if (fetch_ready) begin
        fetch_valid <= 1'b0;
      end
    end
  end

  // Line data, tags and packet payload
  always_ff @(posedge clock) begin
    if (rsp_now) begin
      lines[pc_idx] <= mem_rsp.data;
      tags[pc_idx]  <= pc_tag;
    end
    if (take) begin
      fetch_pkt.pc   <= pc;
      fetch_pkt.inst <= cur_inst;
    end
  end

  // Request held until the memory takes it
  req_stable: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

`default_nettype wire

/* src/decode_stage.sv */
// No forwarding; a source with a pending writer stalls here until that writer retires
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   fetch_valid,
  input  vpipe_pkg::fetch_pkt_t  fetch_pkt,
  output logic                   fetch_ready,
  output logic                   dec_valid,
  output vpipe_pkg::decode_pkt_t dec_pkt,
  input  logic                   dec_ready,
  input  vpipe_pkg::exec_pkt_t   wb,      // From commit
  input  logic                   retire   // Commit handshake
);

  vpipe_pkg::opcode_t  op;
  vpipe_pkg::reg_idx_t rd, rs1, rs2;
  vpipe_pkg::status_t  status;
  logic                use_rs1, use_rs2;
  logic                legal, wr_en;

  vpipe_pkg::word_t regs [vpipe_pkg::nregs];
  logic [1:0]       pending [vpipe_pkg::nregs];  // Writers in flight per register

  logic             wb_we, wb_hit_a, wb_hit_b;
  vpipe_pkg::word_t a_val, b_val, b_sel;
  logic             busy_a, busy_b, stall, issue, issue_wr;

  ////////////////////////////////////////////////////////////////////////////
  // Field decode

  assign op  = vpipe_pkg::opcode_t'(fetch_pkt.inst[15:12]);
  assign rd  = fetch_pkt.inst[11:9];
  assign rs1 = fetch_pkt.inst[8:6];
  assign rs2 = fetch_pkt.inst[5:3];

  always_comb begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (op)
      vpipe_pkg::op_add, vpipe_pkg::op_sub, vpipe_pkg::op_and,
      vpipe_pkg::op_or, vpipe_pkg::op_xor: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      vpipe_pkg::op_addi: use_rs1 = 1'b1;
      default: ;  // li, halt, illegal read nothing
    endcase
  end

  assign legal  = op <= vpipe_pkg::op_li;
  assign wr_en  = legal && (rd != '0);  // r0 writes dropped
  assign status = legal ? vpipe_pkg::st_ok :
                  (op == vpipe_pkg::op_halt) ? vpipe_pkg::st_halt : vpipe_pkg::st_illegal;

  ////////////////////////////////////////////////////////////////////////////
  // Register read, write-first

  assign wb_we    = retire && wb.wr_en;
  assign wb_hit_a = wb_we && (wb.rd == rs1);
  assign wb_hit_b = wb_we && (wb.rd == rs2);

  assign a_val = (rs1 == '0) ? '0 : wb_hit_a ? wb.result : regs[rs1];
  assign b_val = (rs2 == '0) ? '0 : wb_hit_b ? wb.result : regs[rs2];

  // Immediates go raw to execute, which extends them
  always_comb begin
    case (op)
      vpipe_pkg::op_addi: b_sel = {{(vpipe_pkg::xlen-6){1'b0}}, fetch_pkt.inst[5:0]};
      vpipe_pkg::op_li:   b_sel = {{(vpipe_pkg::xlen-9){1'b0}}, fetch_pkt.inst[8:0]};
      default:            b_sel = b_val;
    endcase
  end

  // Last writer retiring this cycle is as good as done
  assign busy_a = use_rs1 && (pending[rs1] != 2'd0) && !((pending[rs1] == 2'd1) && wb_hit_a);
  assign busy_b = use_rs2 && (pending[rs2] != 2'd0) && !((pending[rs2] == 2'd1) && wb_hit_b);
  assign stall  = busy_a || busy_b;

  assign fetch_ready = (!dec_valid || dec_ready) && !stall;
  assign issue       = fetch_valid && fetch_ready;
  assign issue_wr    = issue && wr_en;

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid <= 1'b0;
      for (int i = 0; i < vpipe_pkg::nregs; i++) begin
        regs[i]    <= '0;  // Programs start from zeroed registers
        pending[i] <= 2'd0;
      end
    end else begin
      if (issue) dec_valid <= 1'b1;
      else if (dec_ready) dec_valid <= 1'b0;
      if (wb_we && (wb.rd != '0)) regs[wb.rd] <= wb.result;
      for (int i = 0; i < vpipe_pkg::nregs; i++) begin
        if (issue_wr && (rd == i) && !(wb_we && (wb.rd == i))) pending[i] <= pending[i] + 2'd1;
        else if (wb_we && (wb.rd == i) && !(issue_wr && (rd == i))) pending[i] <= pending[i] - 2'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) dec_pkt <= '{pc: fetch_pkt.pc, op: op, rd: rd, wr_en: wr_en,
                            a: a_val, b: b_sel, status: status};
  end

  // Three stage registers bound the writers in flight
  no_overflow: assert property (@(posedge clock) disable iff (reset)
    issue_wr && !(wb_we && (wb.rd == rd)) |-> pending[rd] != 2'd3);

endmodule

`default_nettype wire

/* src/execute_stage.sv */
// Single-cycle ALU; halt and illegal flow through with a zero result
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dec_valid,
  input  vpipe_pkg::decode_pkt_t dec_pkt,
  output logic                   dec_ready,
  output logic                   ex_valid,
  output vpipe_pkg::exec_pkt_t   ex_pkt,
  input  logic                   ex_ready
);

  vpipe_pkg::word_t imm_s6;   // addi immediate
  vpipe_pkg::word_t imm_u9;   // li immediate
  vpipe_pkg::word_t result;
  logic             take;

  ////////////////////////////////////////////////////////////////////////////
  // Immediates

  assign imm_s6 = {{(vpipe_pkg::xlen-6){dec_pkt.b[5]}}, dec_pkt.b[5:0]};  // Sign extend
  assign imm_u9 = {{(vpipe_pkg::xlen-9){1'b0}}, dec_pkt.b[8:0]};

  ////////////////////////////////////////////////////////////////////////////
  // ALU

  always_comb begin
    case (dec_pkt.op)
      vpipe_pkg::op_add:  result = dec_pkt.a + dec_pkt.b;
      vpipe_pkg::op_sub:  result = dec_pkt.a - dec_pkt.b;
      vpipe_pkg::op_and:  result = dec_pkt.a & dec_pkt.b;
      vpipe_pkg::op_or:   result = dec_pkt.a | dec_pkt.b;
      vpipe_pkg::op_xor:  result = dec_pkt.a ^ dec_pkt.b;
      vpipe_pkg::op_addi: result = dec_pkt.a + imm_s6;
      vpipe_pkg::op_li:   result = imm_u9;
      default:            result = '0;  // Halt and illegal
    endcase
  end

  // Accept when the output register is free or draining
  assign dec_ready = !ex_valid || ex_ready;
  assign take      = dec_valid && dec_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (take) begin
      ex_valid <= 1'b1;
    end else if (ex_ready) begin
      ex_valid <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clock) begin
    if (take) begin
      ex_pkt.pc     <= dec_pkt.pc;
      ex_pkt.rd     <= dec_pkt.rd;
      ex_pkt.wr_en  <= dec_pkt.wr_en;
      ex_pkt.result <= result;
      ex_pkt.status <= dec_pkt.status;  // Pass through
    end
  end

endmodule

`default_nettype wire

/* src/commit_stage.sv */
// Retire happens only on the commit handshake; halted stays set until reset
`timescale 1ns/1ns
`default_nettype none

module commit_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  ex_valid,
  input  vpipe_pkg::exec_pkt_t  ex_pkt,
  output logic                  ex_ready,
  output logic                  commit_valid,
  output vpipe_pkg::commit_t    commit,
  input  logic                  commit_ready,
  output vpipe_pkg::exec_pkt_t  wb,      // Back to decode
  output logic                  retire,
  output logic                  halted
);

  logic take;

  assign ex_ready = !commit_valid || commit_ready;
  assign take     = ex_valid && ex_ready;
  assign retire   = commit_valid && commit_ready;  // Port handshake

  // Writeback mirrors the committing packet
  assign wb = '{pc: commit.pc, rd: commit.rd, wr_en: commit.wr_en,
                result: commit.data, status: commit.status};

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      if (take) commit_valid <= 1'b1;
      else if (commit_ready) commit_valid <= 1'b0;
      // Sticky once halt or illegal leaves the core
      if (retire && (commit.status != vpipe_pkg::st_ok)) halted <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      commit.pc     <= ex_pkt.pc;
      commit.rd     <= ex_pkt.rd;
      commit.wr_en  <= ex_pkt.wr_en;
      commit.data   <= ex_pkt.result;
      commit.status <= ex_pkt.status;
    end
  end

  // Port holds under back-pressure
  commit_stable: assert property (@(posedge clock) disable iff (reset)
    commit_valid && !commit_ready |=> commit_valid && $stable(commit));

endmodule

`default_nettype wire

/* src/vpipe_top.sv */
// Four-stage core with one instruction memory port and one commit port, no data memory
`timescale 1ns/1ns
`default_nettype none

module vpipe_top (
  input  logic                clock,
  input  logic                reset,
  // Instruction memory
  output logic                mem_req_valid,
  output vpipe_pkg::mem_req_t mem_req,
  input  logic                mem_req_ready,
  input  logic                mem_rsp_valid,
  input  vpipe_pkg::mem_rsp_t mem_rsp,
  // Retired instructions
  output logic                commit_valid,
  output vpipe_pkg::commit_t  commit,
  input  logic                commit_ready,
  output logic                halted
);

  logic                   fetch_valid, fetch_ready;  // Fetch to decode
  vpipe_pkg::fetch_pkt_t  fetch_pkt;
  logic                   dec_valid, dec_ready;      // Decode to execute
  vpipe_pkg::decode_pkt_t dec_pkt;
  logic                   ex_valid, ex_ready;        // Execute to commit
  vpipe_pkg::exec_pkt_t   ex_pkt;
  vpipe_pkg::exec_pkt_t   wb;                        // Writeback loop
  logic                   retire;

  ////////////////////////////////////////////////////////////////////////////
  // Input side

  fetch_cache fetch_cache_i (
    .clock(clock), .reset(reset),
    .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_ready(mem_req_ready),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
    .fetch_valid(fetch_valid), .fetch_pkt(fetch_pkt), .fetch_ready(fetch_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Processing

  decode_stage decode_stage_i (
    .clock(clock), .reset(reset),
    .fetch_valid(fetch_valid), .fetch_pkt(fetch_pkt), .fetch_ready(fetch_ready),
    .dec_valid(dec_valid), .dec_pkt(dec_pkt), .dec_ready(dec_ready),
    .wb(wb), .retire(retire)
  );

  execute_stage execute_stage_i (
    .clock(clock), .reset(reset),
    .dec_valid(dec_valid), .dec_pkt(dec_pkt), .dec_ready(dec_ready),
    .ex_valid(ex_valid), .ex_pkt(ex_pkt), .ex_ready(ex_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output side

  commit_stage commit_stage_i (
    .clock(clock), .reset(reset),
    .ex_valid(ex_valid), .ex_pkt(ex_pkt), .ex_ready(ex_ready),
    .commit_valid(commit_valid), .commit(commit), .commit_ready(commit_ready),
    .wb(wb), .retire(retire), .halted(halted)
  );

endmodule

`default_nettype wire

/* sim/clock_gen.sv */
// 40 ns clock from time 0; reset high for 3 rising edges at start and after each reset_req
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
  input  logic reset_req,  // Sampled on the rising edge
  output logic clock,
  output logic reset
);

  localparam int half_period_ns = 20;
  localparam int reset_cycles   = 3;

  int count;  // Reset edges still to go

  initial begin
    clock = 1'b0;
    forever #(half_period_ns) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    count = reset_cycles - 1;  // Initial value covers the first edge
  end

  // Reset moves 2 ns after the edge, like all other stimulus
  always @(posedge clock) begin
    if (reset_req) count = reset_cycles;
    #2;
    if (count != 0) begin
      reset = 1'b1;
      count = count - 1;
    end else begin
      reset = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* sim/vpipe_tb.sv */
// Self-checking; 12 random programs of 30 to 60 instructions, first error ends the run
`timescale 1ns/1ns
`default_nettype none

module vpipe_tb;

  localparam int          num_programs = 12;
  localparam int          max_len      = 60;
  localparam int          illegal_prog = 7;   // This one ends in an illegal opcode
  localparam int          drain_cycles = 20;  // Quiet time checked after the last commit
  localparam int          timeout_ns   = num_programs * max_len * 40 * 40;
  localparam logic [31:0] seed         = 32'h079b_8792;

  logic                clock, reset, reset_req;
  logic                mem_req_valid, mem_req_ready, mem_rsp_valid;
  vpipe_pkg::mem_req_t mem_req;
  vpipe_pkg::mem_rsp_t mem_rsp;
  logic                commit_valid, commit_ready, halted;
  vpipe_pkg::commit_t  commit;

  vpipe_pkg::inst_t    mem [256];      // Instruction memory image
  vpipe_pkg::commit_t  exp_q [$];      // Model retire order
  vpipe_pkg::commit_t  held_commit;
  vpipe_pkg::pc_t      rsp_addr;
  logic [31:0]         prog_rng, bus_rng;
  int                  req_idx, rsp_count, lines_expected, ready_level;
  logic                rsp_fire, hold_valid, retired_last, active;

  clock_gen clock_gen_i (.reset_req(reset_req), .clock(clock), .reset(reset));

  vpipe_top vpipe_top_i (
    .clock(clock), .reset(reset),
    .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_ready(mem_req_ready),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
    .commit_valid(commit_valid), .commit(commit), .commit_ready(commit_ready),
    .halted(halted)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] prog_rand();
    prog_rng = xorshift32(prog_rng);
    return prog_rng;
  endfunction

  function automatic logic [31:0] bus_rand();
    bus_rng = xorshift32(bus_rng);
    return bus_rng;
  endfunction

  // Word k in bits k*16+15 .. k*16
  function automatic vpipe_pkg::line_t line_at(input vpipe_pkg::pc_t addr);
    vpipe_pkg::line_t line;
    for (int k = 0; k < vpipe_pkg::line_words; k++) line[k*16 +: 16] = mem[int'(addr) + k];
    return line;
  endfunction

  function automatic string commit_text(input vpipe_pkg::commit_t c);
    return $sformatf("pc=%h rd=%0d wr_en=%b data=%h %s",
                     c.pc, c.rd, c.wr_en, c.data, c.status.name());
  endfunction

  task automatic stop_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic check_commit(input vpipe_pkg::commit_t got, input vpipe_pkg::commit_t exp,
                              input string what);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s commit %s, expected %s",
               $time, what, commit_text(got), commit_text(exp));
      stop_with_failure();
    end
  endtask

  task automatic check_req(input vpipe_pkg::mem_req_t got, input vpipe_pkg::mem_req_t exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: memory request addr=%h, expected %h", $time, got.addr, exp.addr);
      stop_with_failure();
    end
  endtask

  task automatic check_halted(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: halted=%b, expected %b", $time, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s=%b, expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Program generator and instruction-set model

  task automatic build_program(input int p);
    int                 len;
    int                 base;
    logic [31:0]        r;
    logic [3:0]         op;
    logic [2:0]         rd, rs1, rs2;
    vpipe_pkg::inst_t   inst;
    vpipe_pkg::word_t   regs [8];
    vpipe_pkg::word_t   a, b, res;
    vpipe_pkg::status_t st;
    vpipe_pkg::commit_t c;
    len  = 30 + int'(prog_rand() % 31);
    base = 0;
    exp_q.delete();
    for (int k = 0; k < 8; k++) regs[k] = '0;
    for (int k = 0; k < 256; k++) mem[k] = {8'(k) ^ 8'h5a, 8'(k)};  // Never executed
    for (int i = 0; i < len; i++) begin
      r = prog_rand();
      if (i == len - 1) begin
        op   = (p == illegal_prog) ? 4'd7 + 4'(r[2:0]) : 4'd15;  // 7..14 or halt
        inst = {op, r[27:16]};
      end else begin
        if (r[3:0] < 4'd4) base = int'(r[6:4]) % 6;  // Move the register window now and then
        op  = 4'(int'(r[10:8]) % 7);
        rd  = 3'(base + int'(r[12:11]) % 3);
        rs1 = 3'(base + int'(r[14:13]) % 3);
        rs2 = 3'(base + int'(r[16:15]) % 3);
        case (op)
          4'd5:    inst = {op, rd, rs1, r[22:17]};
          4'd6:    inst = {op, rd, r[25:17]};
          default: inst = {op, rd, rs1, rs2, r[19:17]};
        endcase
      end
      mem[i] = inst;
      // Execute by the field rules
      rd  = inst[11:9];
      a   = regs[inst[8:6]];  // regs[0] is never written
      b   = regs[inst[5:3]];
      res = '0;
      st  = vpipe_pkg::st_ok;
      case (inst[15:12])
        4'd0:    res = a + b;
        4'd1:    res = a - b;
        4'd2:    res = a & b;
        4'd3:    res = a | b;
        4'd4:    res = a ^ b;
        4'd5:    res = a + {{10{inst[5]}}, inst[5:0]};
        4'd6:    res = {7'd0, inst[8:0]};
        4'd15:   st = vpipe_pkg::st_halt;
        default: st = vpipe_pkg::st_illegal;
      endcase
      c.pc     = vpipe_pkg::pc_t'(i);
      c.rd     = rd;
      c.wr_en  = (st == vpipe_pkg::st_ok) && (rd != 3'd0);
      c.data   = res;
      c.status = st;
      if (c.wr_en) regs[rd] = res;
      exp_q.push_back(c);
    end
    lines_expected = (len - 1) / vpipe_pkg::line_words + 1;
    ready_level    = 3 + p % 6;  // Out of 8, so the last level never stalls
    $display("Program %0d: %0d instructions, commit_ready level %0d/8", p, len, ready_level);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and commit monitor

  // Sampled mid-cycle where every signal is settled
  always @(negedge clock) begin : monitor
    vpipe_pkg::mem_req_t exp_req;
    if (reset || !active) begin
      req_idx      = 0;
      rsp_count    = 0;
      rsp_fire     = 1'b0;
      hold_valid   = 1'b0;
      retired_last = 1'b0;
    end else begin
      check_halted(halted, retired_last);  // Rises one cycle after the last retire
      if (hold_valid) begin
        if (!commit_valid) report_error("commit_valid dropped while commit_ready was low");
        check_commit(commit, held_commit, "held");
      end
      hold_valid  = commit_valid && !commit_ready;
      held_commit = commit;
      if (commit_valid) begin
        if (exp_q.size() == 0) report_error("commit after the program already ended");
        if (commit_ready) begin
          check_commit(commit, exp_q.pop_front(), "retired");
          retired_last = (exp_q.size() == 0);
        end
      end
      rsp_fire = 1'b0;
      if (rsp_count != 0) begin
        rsp_count = rsp_count - 1;
        rsp_fire  = (rsp_count == 0);  // Drive the line next cycle
      end
      if (mem_req_valid) begin
        if (req_idx >= lines_expected) report_error("memory request past the last program line");
        exp_req.addr = vpipe_pkg::pc_t'(req_idx * vpipe_pkg::line_words);  // Ascending lines
        check_req(mem_req, exp_req);
        if (mem_req_ready) begin
          if (rsp_count != 0 || rsp_fire) report_error("second memory request while one is open");
          rsp_addr  = mem_req.addr;
          rsp_count = 1 + int'(bus_rand() % 6);  // 1..6 cycles
          req_idx   = req_idx + 1;
        end
      end
    end
  end

  // Random ready on both ports
  always @(posedge clock) begin : drive_inputs
    logic [31:0] r;
    #2;
    r             = bus_rand();
    commit_ready  = int'(r[2:0]) < ready_level;
    mem_req_ready = r[3];
    mem_rsp_valid = rsp_fire;
    mem_rsp.data  = rsp_fire ? line_at(rsp_addr) : '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  task automatic step_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic restart_core();
    reset_req = 1'b1;
    step_cycle();
    reset_req = 1'b0;
    @(negedge reset);  // Falls 2 ns after an edge
  endtask

  initial begin
    reset_req     = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp       = '0;
    commit_ready  = 1'b0;
    prog_rng      = seed;
    bus_rng       = ~seed;  // Separate stream for the bus
    ready_level   = 8;
    active        = 1'b0;
    @(negedge reset);
    for (int p = 0; p < num_programs; p++) begin
      build_program(p);
      restart_core();
      check_valid("commit_valid", commit_valid, 1'b0);
      check_valid("mem_req_valid", mem_req_valid, 1'b0);
      check_halted(halted, 1'b0);
      active = 1'b1;
      while (!retired_last) step_cycle();
      repeat (drain_cycles) step_cycle();  // No commit or request may follow
      if (req_idx != lines_expected)
        report_error($sformatf("program %0d fetched %0d lines, expected %0d",
                               p, req_idx, lines_expected));
      active = 1'b0;
    end
    $display("All %0d programs retired as the model predicts", num_programs);
    $display("RESULT: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_ns);
    $display("Timeout after %0d ns, the core stopped retiring instructions", timeout_ns);
    stop_with_failure();
  end

endmodule

`default_nettype wire

/* all.f */
src/vpipe_pkg.sv
src/fetch_cache.sv
src/decode_stage.sv
src/execute_stage.sv
src/commit_stage.sv
src/vpipe_top.sv
sim/clock_gen.sv
sim/vpipe_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module vpipe_tb -f all.f \
  && ./obj_dir/Vvpipe_tb > sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log \
  && echo "simulation passed, see sim.log" \
  || { echo "simulation failed, see sim.log"; exit 1; }
